// File: logic/fetch_defs.svh
/*
 * Build-wide sizes for the fetch front end.
 * The window logic assumes a 16-bit bus and a four-byte window.
 * Other values are not supported by the lane and half-word decode.
 */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address width seen by the client and the memory.
`define FETCH_ADDR_W 24

// Data width of one memory read, always an aligned word.
`define FETCH_BUS_W 16

// Number of byte lanes held by the fetch window.
`define FETCH_WIN_BYTES 4

`endif

// File: logic/fetch_pkg.sv
/*
 * Types shared by the fetch front end.
 * Widths come from the defines header, which must be on the include path.
 */
`include "fetch_defs.svh"

package fetch_pkg;

    // Size of one client fetch. Data above the size is returned as zero.
    typedef enum logic [1:0] {
        FETCH_BYTE = 2'd0,
        FETCH_WORD = 2'd1,
        FETCH_LONG = 2'd2
    } fetch_size_t;

    // One client request, held stable while req is high.
    typedef struct packed {
        logic                     use_idx;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] idx_addr;
        fetch_size_t              size;
    } fetch_req_t;

    // Word read command. The spare bit sits where address bit zero would be.
    typedef struct packed {
        logic [`FETCH_ADDR_W-2:0] word_addr;
        logic                     spare;
    } mem_cmd_t;

    // Data word returned by one memory read.
    typedef struct packed {
        logic [`FETCH_BUS_W-1:0] data;
    } mem_rsp_t;

    // The window seen as two half-words.
    typedef struct packed {
        logic [`FETCH_BUS_W-1:0] hi;
        logic [`FETCH_BUS_W-1:0] lo;
    } fetch_half_t;

    // Lane zero is the byte at the window start, so the low half is little-endian.
    typedef union packed {
        logic [`FETCH_WIN_BYTES-1:0][7:0] bytes;
        fetch_half_t                      half;
    } fetch_win_u;

endpackage

// File: logic/fetch_window.sv
/*
 * Four-byte fetch window filled by aligned 16-bit word reads.
 * Only one read is outstanding. fetch_addr must stay steady while active.
 * Advances of one to three bytes keep the surviving lanes.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_window (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`FETCH_ADDR_W-1:0] fetch_addr,
    input  logic                     fetch_active,
    output logic                     rd_valid,
    output fetch_pkg::mem_cmd_t      rd_cmd,
    input  logic                     rd_done,
    input  fetch_pkg::mem_rsp_t      rd_rsp,
    output fetch_pkg::fetch_win_u    win,
    output logic                     win_ready
);
    import fetch_pkg::*;

    localparam int LANES = `FETCH_WIN_BYTES;
    localparam int SH_W  = $clog2(LANES);

    // Byte address held in lane zero.
    logic [`FETCH_ADDR_W-1:0] start_q;
    // Lanes holding good data, and lanes still waiting for a read.
    logic [LANES-1:0]         lane_ok;
    logic [LANES-1:0]         lane_pend;
    // Word address of the read being requested.
    logic [`FETCH_ADDR_W-2:0] rd_word;
    fetch_win_u               win_q;

    logic [`FETCH_ADDR_W-1:0] addr_diff;
    logic [SH_W-1:0]          adv;
    logic [LANES-1:0]         keep_mask;
    logic [`FETCH_ADDR_W-1:0] next_fill;
    logic [LANES-1:0]         lane_hit;
    logic [LANES-1:0]         lane_odd;
    logic                     hit;
    logic                     miss;
    logic                     can_shift;

    // The window matches when every lane is good and it starts at the asked address.
    assign hit       = (&lane_ok) && (start_q == fetch_addr);
    assign win_ready = fetch_active && hit;

    // A new window is only set up once the previous fill is complete.
    assign miss      = fetch_active && !hit && (lane_pend == '0);

    // Distance of the new address past the current start.
    assign addr_diff = fetch_addr - start_q;
    assign adv       = addr_diff[SH_W-1:0];
    assign keep_mask = {LANES{1'b1}} >> adv;

    // A shift is only worth it when all lanes that survive it are good.
    assign can_shift = (addr_diff < `FETCH_ADDR_W'(LANES)) && (adv != '0) &&
                       ((lane_ok >> adv) == keep_mask);

    // After a shift the first missing byte is the one just past the old window.
    assign next_fill = start_q + `FETCH_ADDR_W'(LANES);

    // For each lane, check whether the returned word covers it and which half holds it.
    always_comb begin : lane_map
        logic [`FETCH_ADDR_W-1:0] lane_addr;
        for (int i = 0; i < LANES; i++) begin
            lane_addr   = start_q + `FETCH_ADDR_W'(i);
            lane_hit[i] = lane_pend[i] && (lane_addr[`FETCH_ADDR_W-1:1] == rd_word);
            lane_odd[i] = lane_addr[0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q   <= '0;
            lane_ok   <= '0;
            lane_pend <= '0;
            rd_word   <= '0;
        end else begin
            // A returned word settles the lanes it covers.
            // Pending lanes are always the top ones, so the next word is simply one up.
            if (rd_done) begin
                for (int i = 0; i < LANES; i++) begin
                    if (lane_hit[i]) begin
                        lane_ok[i]   <= 1'b1;
                        lane_pend[i] <= 1'b0;
                    end
                end
                rd_word <= rd_word + 1'b1;
            end
            if (miss) begin
                start_q <= fetch_addr;
                if (can_shift) begin
                    lane_ok   <= keep_mask;
                    lane_pend <= ~keep_mask;
                    rd_word   <= next_fill[`FETCH_ADDR_W-1:1];
                end else begin
                    lane_ok   <= '0;
                    lane_pend <= '1;
                    rd_word   <= fetch_addr[`FETCH_ADDR_W-1:1];
                end
            end
        end
    end

    // Window bytes. The even address is the low byte of a memory word.
    always_ff @(posedge clk) begin
        if (miss && can_shift) begin
            win_q.bytes <= win_q.bytes >> {adv, 3'b000};
        end else if (rd_done) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_hit[i]) begin
                    win_q.bytes[i] <= lane_odd[i] ? rd_rsp.data[`FETCH_BUS_W-1:8] :
                                                    rd_rsp.data[7:0];
                end
            end
        end
    end

    // The request stays up until the last pending lane is filled.
    // It drops for the response pulse while the word address moves on.
    assign rd_valid = (lane_pend != '0) && !rd_done;
    assign rd_cmd   = '{word_addr: rd_word, spare: 1'b0};
    assign win      = win_q;

    // A held request keeps its word address until its response has come back.
    a_rd_held: assert property (@(posedge clk) disable iff (rst)
        rd_valid && $past(rd_valid) |-> $stable(rd_cmd));

    // Ready only comes up once the fill has fully landed and no read is still out.
    a_ready_full: assert property (@(posedge clk) disable iff (rst)
        win_ready |-> (lane_pend == '0) && !rd_done);

endmodule

// File: logic/ram_bus_port.sv
/*
 * Four-phase read requester toward a 16-bit memory.
 * One read is in flight. rd_done pulses only after mem_ack has dropped.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ram_bus_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_valid,
    input  fetch_pkg::mem_cmd_t      rd_cmd,
    output logic                     rd_done,
    output fetch_pkg::mem_rsp_t      rd_rsp,
    output logic                     mem_req,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_ack,
    input  logic [`FETCH_BUS_W-1:0]  mem_data
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WAIT_HI = 2'd1,
        ST_WAIT_LO = 2'd2
    } bus_state_t;

    bus_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                // Take a new read only when the previous handshake is fully closed.
                ST_IDLE: begin
                    if (rd_valid) begin
                        mem_req <= 1'b1;
                        state   <= ST_WAIT_HI;
                    end
                end
                // Data is valid while ack is high, so drop req on the rising ack.
                ST_WAIT_HI: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_WAIT_LO;
                    end
                end
                // The read is complete once the memory releases ack.
                ST_WAIT_LO: begin
                    if (!mem_ack) begin
                        rd_done <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and data registers carry no reset.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rd_valid) begin
            mem_addr <= {rd_cmd.word_addr, 1'b0};
        end
        if (state == ST_WAIT_HI && mem_ack) begin
            rd_rsp.data <= mem_data;
        end
    end

    // The memory may sample the address at any point of the handshake.
    // The word asked for must therefore not move while req is up.
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> (mem_addr == {rd_cmd.word_addr, 1'b0}));

endmodule

// File: logic/fetch_client_port.sv
/*
 * Four-phase responder toward the CPU sequencer.
 * The client must hold req_info stable while req is high.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_client_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  fetch_pkg::fetch_req_t    req_info,
    output logic                     ack,
    output logic [31:0]              data,
    output logic [`FETCH_ADDR_W-1:0] fetch_addr,
    output logic                     fetch_active,
    input  fetch_pkg::fetch_win_u    win,
    input  logic                     win_ready
);
    import fetch_pkg::*;

    logic        start;
    logic [31:0] sized_data;

    // A request is taken once the previous ack has dropped.
    assign start = req && !ack && !fetch_active;

    // Bytes above the requested size read as zero.
    always_comb begin
        case (req_info.size)
            FETCH_BYTE: sized_data = {24'h0, win.bytes[0]};
            FETCH_WORD: sized_data = {16'h0, win.half.lo};
            default:    sized_data = {win.half.hi, win.half.lo};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack          <= 1'b0;
            fetch_active <= 1'b0;
            fetch_addr   <= '0;
        end else begin
            if (start) begin
                fetch_addr   <= req_info.use_idx ? req_info.idx_addr : req_info.pc;
                fetch_active <= 1'b1;
            end else if (fetch_active && win_ready) begin
                fetch_active <= 1'b0;
                ack          <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // Data is captured with the rising ack and held until the next one.
    always_ff @(posedge clk) begin
        if (fetch_active && win_ready) begin
            data <= sized_data;
        end
    end

    // The client keeps req up until it sees ack.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req);

endmodule

// File: logic/fetch_unit.sv
/*
 * Fetch front end top level. Client and memory both use four-phase req/ack.
 * Memory reads are aligned 16-bit words with one read in flight.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  fetch_pkg::fetch_req_t    req_info,
    output logic                     ack,
    output logic [31:0]              data,
    output logic                     mem_req,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_ack,
    input  logic [`FETCH_BUS_W-1:0]  mem_data
);
    import fetch_pkg::*;

    logic [`FETCH_ADDR_W-1:0] fetch_addr;
    logic                     fetch_active;
    logic                     rd_valid;
    mem_cmd_t                 rd_cmd;
    logic                     rd_done;
    mem_rsp_t                 rd_rsp;
    fetch_win_u               win;
    logic                     win_ready;

    // Client handshake and address source select.
    fetch_client_port i_client (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_info     (req_info),
        .ack          (ack),
        .data         (data),
        .fetch_addr   (fetch_addr),
        .fetch_active (fetch_active),
        .win          (win),
        .win_ready    (win_ready)
    );

    fetch_window i_window (
        .clk          (clk),
        .rst          (rst),
        .fetch_addr   (fetch_addr),
        .fetch_active (fetch_active),
        .rd_valid     (rd_valid),
        .rd_cmd       (rd_cmd),
        .rd_done      (rd_done),
        .rd_rsp       (rd_rsp),
        .win          (win),
        .win_ready    (win_ready)
    );

    // Memory handshake.
    ram_bus_port i_bus (
        .clk      (clk),
        .rst      (rst),
        .rd_valid (rd_valid),
        .rd_cmd   (rd_cmd),
        .rd_done  (rd_done),
        .rd_rsp   (rd_rsp),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

endmodule

// File: verif/tb_mem_responder.sv
/*
 * Memory model for the fetch testbench. Byte a holds the low byte of 7*a + 3.
 * Each read waits 0 to 3 extra cycles, drawn from a seeded Galois LFSR.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_mem_responder #(
    parameter logic [15:0] SEED = 16'd48528
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_req,
    input  logic [`FETCH_ADDR_W-1:0] mem_addr,
    output logic                     mem_ack,
    output logic [`FETCH_BUS_W-1:0]  mem_data,
    output int                       read_count
);

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_ACK} mem_state_t;

    mem_state_t  state;
    logic [15:0] lfsr;
    logic [1:0]  wait_left;

    // Content of one byte of memory.
    function automatic logic [7:0] mem_byte(input logic [`FETCH_ADDR_W-1:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'd7 + 32'd3;
        return v[7:0];
    endfunction

    // One step of a 16-bit Galois LFSR with a maximal-length tap set.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    always @(posedge clk or posedge rst) begin
        logic [15:0] next_lfsr;
        logic [1:0]  waits;
        if (rst) begin
            state      <= M_IDLE;
            mem_ack    <= 1'b0;
            mem_data   <= '0;
            lfsr       <= SEED;
            wait_left  <= '0;
            read_count <= 0;
        end else begin
            case (state)
                // Two LFSR bits give the wait count, one step per bit.
                M_IDLE: begin
                    if (mem_req) begin
                        waits[0]  = lfsr[0];
                        next_lfsr = lfsr_step(lfsr);
                        waits[1]  = next_lfsr[0];
                        lfsr      <= lfsr_step(next_lfsr);
                        wait_left <= waits;
                        state     <= M_WAIT;
                    end
                end
                // The even address is the low byte of the word.
                M_WAIT: begin
                    if (wait_left == 2'd0) begin
                        mem_data   <= {mem_byte({mem_addr[`FETCH_ADDR_W-1:1], 1'b1}),
                                       mem_byte({mem_addr[`FETCH_ADDR_W-1:1], 1'b0})};
                        mem_ack    <= 1'b1;
                        read_count <= read_count + 1;
                        state      <= M_ACK;
                    end else begin
                        wait_left <= wait_left - 2'd1;
                    end
                end
                // Ack is held until the requester lets go of req.
                default: begin
                    if (!mem_req) begin
                        mem_ack <= 1'b0;
                        state   <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: verif/fetch_unit_tb.sv
/*
 * Testbench for the fetch front end. Run from the project root, since the
 * stimulus file path is relative to it. Wait states are seeded and repeatable.
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam int    CLK_PERIOD       = 4;
    localparam int    RESET_CYCLES     = 4;
    localparam int    CYCLES_PER_FETCH = 200;
    localparam int    HANDSHAKE_LIMIT  = 100;
    localparam string STIM_PATH        = "verif/fetch_stim.txt";

    // One fetch from the stimulus file.
    typedef struct packed {
        logic                     use_idx;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] idx_addr;
        logic [1:0]               size;
        logic [15:0]              hold;
        logic [31:0]              exp_data;
        logic [3:0]               exp_reads;
    } stim_line_t;

    logic                     clk;
    logic                     rst;
    logic                     req;
    fetch_req_t               req_info;
    logic                     ack;
    logic [31:0]              data;
    logic                     mem_req;
    logic [`FETCH_ADDR_W-1:0] mem_addr;
    logic                     mem_ack;
    logic [`FETCH_BUS_W-1:0]  mem_data;
    int                       read_count;
    logic                     mem_req_q;
    logic [`FETCH_ADDR_W-1:0] mem_addr_q;
    stim_line_t               stim_q[$];
    logic                     stim_loaded = 1'b0;
    int                       check_count = 0;
    int                       value_errors = 0;
    int                       other_errors = 0;

    fetch_unit i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_info (req_info),
        .ack      (ack),
        .data     (data),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    tb_mem_responder #(.SEED(16'd48528)) i_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data),
        .read_count (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s: expected 0x%08h, got 0x%08h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, value errors: %0d, other errors: %0d", check_count,
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic load_stim();
        int         fd;
        int         fields;
        int         src;
        int         size;
        int         hold;
        int         reads;
        logic [31:0] pc;
        logic [31:0] idx;
        logic [31:0] exp_data;
        string      line;
        stim_line_t s;
        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_PATH);
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines carry no fetch.
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d %h %h %d %d %h %d", src, pc, idx, size, hold,
                             exp_data, reads);
            if (fields != 7) begin
                $display("Stimulus line could not be parsed: %s", line);
                other_errors++;
                continue;
            end
            s.use_idx   = src[0];
            s.pc        = pc[`FETCH_ADDR_W-1:0];
            s.idx_addr  = idx[`FETCH_ADDR_W-1:0];
            s.size      = size[1:0];
            s.hold      = hold[15:0];
            s.exp_data  = exp_data;
            s.exp_reads = reads[3:0];
            stim_q.push_back(s);
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("The stimulus file holds no fetches");
            other_errors++;
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change.
    task automatic wait_for_ack(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack !== level && cycles < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (ack === level);
        if (!ok) begin
            $display("No ack %s within %0d cycles", level ? "rise" : "fall", HANDSHAKE_LIMIT);
            other_errors++;
        end
    endtask

    // One full four-phase client transaction.
    task automatic run_fetch(input stim_line_t s, output logic ok);
        fetch_req_t info;
        int         reads_before;
        info.use_idx  = s.use_idx;
        info.pc       = s.pc;
        info.idx_addr = s.idx_addr;
        info.size     = fetch_size_t'(s.size);
        @(posedge clk);
        req          <= 1'b1;
        req_info     <= info;
        reads_before = read_count;
        wait_for_ack(1'b1, ok);
        if (!ok) begin
            return;
        end
        compare("data", s.exp_data, data);
        compare("reads", 32'(s.exp_reads), 32'(read_count - reads_before));
        // A client that keeps req up must see ack and data unchanged.
        repeat (s.hold) begin
            @(negedge clk);
            compare("ack", 32'd1, 32'(ack));
            compare("data", s.exp_data, data);
        end
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0, ok);
    endtask

    // The memory may look at the address at any time during its handshake.
    always @(negedge clk) begin
        if (!rst && mem_req && mem_req_q) begin
            compare("mem_addr", 32'(mem_addr_q), 32'(mem_addr));
        end
        mem_req_q  <= mem_req;
        mem_addr_q <= mem_addr;
    end

    initial begin : main
        logic ok;
        rst      = 1'b1;
        req      = 1'b0;
        req_info = '0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("ack", 32'd0, 32'(ack));
        compare("mem_req", 32'd0, 32'(mem_req));
        ok = 1'b1;
        for (int i = 0; i < stim_q.size() && ok; i++) begin
            run_fetch(stim_q[i], ok);
        end
        end_run();
    end

    // The limit scales with the number of fetches in the file.
    initial begin : watchdog
        wait (stim_loaded === 1'b1);
        repeat ((stim_q.size() + 1) * CYCLES_PER_FETCH) @(posedge clk);
        $display("Watchdog expired before all fetches were done");
        other_errors++;
        end_run();
    end

endmodule

// File: verif/fetch_stim.txt
# One fetch per line: src pc idx size hold data reads (hex for pc, idx and data).
# src 1 selects idx; size 0 byte, 1 word, 2 long; hold is extra cycles with req high.
# reads is the number of memory word reads that the fetch should cause.
0 000100 000000 2 0 18110A03 2
0 000101 000000 2 1 1F18110A 1
0 000103 000000 2 0 2D261F18 2
0 000103 000000 1 2 00001F18 0
0 000106 000000 2 0 423B342D 2
0 000107 000000 0 0 00000034 1
1 000108 002041 2 5 DFD8D1CA 3
1 000000 002043 1 0 0000DFD8 2
0 002044 000000 2 0 F4EDE6DF 1
0 002047 000000 2 3 0902FBF4 2
0 00204B 000000 2 0 251E1710 3
0 00204A 000000 1 12 00001009 2
0 FFFFFE 000000 2 0 0A03FCF5 2
0 FFFFFF 000000 2 0 110A03FC 1
1 123456 000001 2 20 1F18110A 2
0 000001 000000 0 0 0000000A 0
0 005555 000000 2 7 6B645D56 3
0 005556 000000 0 0 0000005D 1
0 005558 000000 1 0 0000726B 1
1 000000 0000FF 2 3 110A03FC 3

// File: all.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_window.sv
logic/ram_bus_port.sv
logic/fetch_client_port.sv
logic/fetch_unit.sv
verif/tb_mem_responder.sv
verif/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run for the fetch front end testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All checks passed

SOURCES := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)
